// ==== verif/prog.hex ====
// One 32-bit instruction word per line, hex, loaded from word 0x40 (PC 0x100)
// Trailing text gives the byte address and the assembly
@40
80F08001 // 100 addi r1, r0, 0xF080   KEY address
80F00002 // 104 addi r2, r0, 0xF000   HEX address
80000408 // 108 addi r8, r0, 4        shift amount
48000013 // 10C loop: lw r3, 0(r1)    k
80000809 // 110 addi r9, r0, 8
94005A0F // 114 ori r15, r0, 0x5A
68020003 // 118 sw r3, 0x200(r0)
48020004 // 11C lw r4, 0x200(r0)
98000F36 // 120 xori r6, r3, 15       b
9000FF1C // 124 andi r12, r1, 0xFF
80000345 // 128 addi r5, r4, 3
00900C49 // 12C and r12, r4, r9
00A00D49 // 130 sub r13, r4, r9
00C40558 // 134 lshf r5, r5, r8       a
00B00A46 // 138 nand r10, r4, r6
00B80B46 // 13C nxor r11, r4, r6
00940756 // 140 or r7, r5, r6
24000149 // 144 blt r4, r9, 14C
20000100 // 148 beq r0, r0, 150
80010077 // 14C addi r7, r7, 0x100
3000570E // 150 jal r14, 0x57(r0)
68000027 // 154 sw r7, 0(r2)
20FFEC00 // 158 beq r0, r0, 10C
80100077 // 15C sub: addi r7, r7, 0x1000
300000EF // 160 jal r15, 0(r14)       return

// ==== files.f ====
src/cpu_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/reg_file.sv
src/execute_stage.sv
src/memory_stage.sv
src/cpu_top.sv
verif/cpu_asserts.sv
verif/cpu_tb.sv

// ==== verif/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

  // Key table size
  localparam int num_rows    = 11;
  // Rows ahead of the random ones
  localparam int fixed_rows  = 7;
  // Cycles that hex must then hold through two program loops
  localparam int hold_cycles = 80;
  // Watchdog limit scaled by the table length
  localparam int cycle_limit = 400 * num_rows + 100;

  logic                clk = 1'b0;
  logic                reset;
  logic [key_bits-1:0] key;
  logic [hex_bits-1:0] hex;

  logic [key_bits-1:0] key_tab [num_rows];
  logic [hex_bits-1:0] exp_tab [num_rows];
  integer              seed = 32'hf2580954;
  int                  cycle_count = 0;
  int                  cur_row = 0;

  cpu_top dut_i (.clk, .reset, .key, .hex);

  // 4 ns clock
  always #2 clk = ~clk;

  // **************************************************
  // Reference values
  // **************************************************
  // Expected hex from the inverted key k
  // ((k+3)<<4 | k^15) + 0x1000 and another 0x100 when k < 8
  function automatic logic [hex_bits-1:0] hex_for_key(input logic [key_bits-1:0] key_val);
    logic [key_bits-1:0] kv;
    int                  k;
    int                  v;
    kv = ~key_val;
    k  = kv;
    v  = (((k + 3) << 4) | (k ^ 15)) + 'h1000;
    if (k < 8) begin
      v = v + 'h100;
    end
    return v[hex_bits-1:0];
  endfunction

  task automatic stop_on_error();
    $display("Finished with errors");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  // Poll on the falling edge where hex is stable
  task automatic wait_for_hex(input logic [hex_bits-1:0] exp_val);
    while (hex !== exp_val) begin
      @(negedge clk);
    end
  endtask

  // Watchdog
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: key row %0d (key %b) never produced hex %06h within %0d cycles",
               cur_row, key_tab[cur_row], exp_tab[cur_row], cycle_limit);
      stop_on_error();
    end
  end

  // **************************************************
  // Stimulus and checks
  // **************************************************
  initial begin
    // k of 0 takes the BLT
    key_tab[0] = 4'b1111;
    // k of 9 and 12 fall through it
    key_tab[1] = 4'b0110;
    key_tab[2] = 4'b0011;
    // k = 1, 7, 8 and 15 around the BLT boundary
    key_tab[3] = 4'b1110;
    key_tab[4] = 4'b1000;
    key_tab[5] = 4'b0111;
    key_tab[6] = 4'b0000;
    for (int i = fixed_rows; i < num_rows; i++) begin
      key_tab[i] = key_bits'($random(seed));
      // Each row must move hex
      if (key_tab[i] == key_tab[i-1]) begin
        key_tab[i] = ~key_tab[i];
      end
    end
    for (int i = 0; i < num_rows; i++) begin
      exp_tab[i] = hex_for_key(key_tab[i]);
    end

    reset = 1'b0;
    key   = key_tab[0];
    #1;
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;

    // Reset value holds until the first store
    @(negedge clk);
    assert (hex === hex_reset) else begin
      $display("error at time %0t: hex after reset expected %06h, got %06h",
               $time, hex_reset, hex);
      stop_on_error();
    end

    for (int i = 0; i < num_rows; i++) begin
      cur_row = i;
      @(posedge clk);
      #1;
      key = key_tab[i];
      wait_for_hex(exp_tab[i]);
      // Loop branch keeps storing the same value
      repeat (hold_cycles) begin
        @(negedge clk);
        assert (hex === exp_tab[i]) else begin
          $display("error at time %0t: key %b hex changed from %06h to %06h",
                   $time, key_tab[i], exp_tab[i], hex);
          stop_on_error();
        end
      end
    end

    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== verif/cpu_asserts.sv ====
`timescale 1ns/1ps

module cpu_asserts import cpu_pkg::*; (
  input logic                clk,
  input logic                reset,
  input logic [dbits-1:0]    f_pc,
  input inst_t               f_inst,
  input logic                ctrl_in_decode,
  input logic                redirect,
  input logic [hex_bits-1:0] hex
);

  // Fetch PC on a word boundary
  assert property (@(posedge clk) disable iff (reset) f_pc[1:0] == 2'b00)
    else $error("fetch PC %h is not word aligned", f_pc);

  // Redirect is a single cycle pulse
  assert property (@(posedge clk) disable iff (reset) redirect |=> !redirect)
    else $error("redirect stayed high for two cycles");

  // Control instruction in decode, bubble into the fetch latch
  assert property (@(posedge clk) disable iff (reset) ctrl_in_decode |=> f_inst == nop_inst)
    else $error("fetch latch not a bubble after a control instruction in decode");

  // HEX holds its reset value
  assert property (@(posedge clk) reset |-> hex == hex_reset)
    else $error("hex is %h during reset", hex);

endmodule

bind cpu_top cpu_asserts asserts_i (.clk, .reset, .f_pc, .f_inst, .ctrl_in_decode,
  .redirect, .hex);

// ==== src/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic [key_bits-1:0] key,
  output logic [hex_bits-1:0] hex
);

  // **************************************************
  // Inter-stage wires
  // **************************************************
  // Fetch to decode
  inst_t                 f_inst;
  logic [dbits-1:0]      f_pc;
  // Register file ports
  logic [regno_bits-1:0] rs, rt;
  logic [dbits-1:0]      rdata1, rdata2;
  // Decode to execute
  inst_t                 d_inst;
  logic [dbits-1:0]      d_pc, d_val1, d_val2, d_imm;
  logic [regno_bits-1:0] d_wregno;
  logic                  d_wr_reg, d_rd_mem, d_wr_mem, d_is_branch, d_is_jal;
  // Control back to fetch
  logic                  ctrl_in_decode, ctrl_in_execute, redirect;
  logic [dbits-1:0]      redirect_pc;
  // Execute to memory
  logic [dbits-1:0]      e_alu_out, e_store_data;
  logic [regno_bits-1:0] e_wregno;
  logic                  e_wr_reg, e_rd_mem, e_wr_mem;
  // Write back
  logic                  wb_en;
  logic [regno_bits-1:0] wb_regno;
  logic [dbits-1:0]      wb_data;

  fetch_stage fetch_i (.clk, .reset, .ctrl_in_decode, .ctrl_in_execute, .redirect,
    .redirect_pc, .inst(f_inst), .pc(f_pc));

  decode_stage decode_i (.clk, .reset, .inst(f_inst), .pc(f_pc), .rdata1, .rdata2, .rs, .rt,
    .d_inst, .d_pc, .d_val1, .d_val2, .d_imm, .d_wregno, .d_wr_reg, .d_rd_mem, .d_wr_mem,
    .d_is_branch, .d_is_jal, .ctrl_in_decode);

  reg_file reg_file_i (.clk, .reset, .rs, .rt, .wb_en, .wb_regno, .wb_data, .rdata1, .rdata2);

  execute_stage execute_i (.clk, .reset, .d_inst, .d_pc, .d_val1, .d_val2, .d_imm, .d_wregno,
    .d_wr_reg, .d_rd_mem, .d_wr_mem, .d_is_branch, .d_is_jal, .e_alu_out, .e_store_data,
    .e_wregno, .e_wr_reg, .e_rd_mem, .e_wr_mem, .ctrl_in_execute, .redirect, .redirect_pc);

  memory_stage memory_i (.clk, .reset, .e_alu_out, .e_store_data, .e_wregno, .e_wr_reg,
    .e_rd_mem, .e_wr_mem, .key, .wb_en, .wb_regno, .wb_data, .hex);

endmodule

// ==== src/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage import cpu_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [dbits-1:0]      e_alu_out,
  input  logic [dbits-1:0]      e_store_data,
  input  logic [regno_bits-1:0] e_wregno,
  input  logic                  e_wr_reg,
  input  logic                  e_rd_mem,
  input  logic                  e_wr_mem,
  input  logic [key_bits-1:0]   key,
  output logic                  wb_en,
  output logic [regno_bits-1:0] wb_regno,
  output logic [dbits-1:0]      wb_data,
  output logic [hex_bits-1:0]   hex
);

  logic [dbits-1:0]           dmem [mem_words];
  logic [mem_addr_bits-3:0]   widx;
  logic [dbits-1:0]           rd_val;

  // Word index from the byte address
  assign widx = e_alu_out[mem_addr_bits-1:2];

  // KEY pins are active low
  assign rd_val = (e_alu_out == addr_key) ? {{(dbits-key_bits){1'b0}}, ~key} : dmem[widx];

  // Data memory write
  always_ff @(posedge clk) begin
    if (e_wr_mem) begin
      dmem[widx] <= e_store_data;
    end
  end

  // HEX output register
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hex <= hex_reset;
    end else if (e_wr_mem && (e_alu_out == addr_hex)) begin
      hex <= e_store_data[hex_bits-1:0];
    end
  end

  // Write-back latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb_en    <= 1'b0;
      wb_regno <= '0;
      wb_data  <= '0;
    end else begin
      wb_en    <= e_wr_reg;
      wb_regno <= e_wregno;
      wb_data  <= e_rd_mem ? rd_val : e_alu_out;
    end
  end

endmodule

// ==== src/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  inst_t                 d_inst,
  input  logic [dbits-1:0]      d_pc,
  input  logic [dbits-1:0]      d_val1,
  input  logic [dbits-1:0]      d_val2,
  input  logic [dbits-1:0]      d_imm,
  input  logic [regno_bits-1:0] d_wregno,
  input  logic                  d_wr_reg,
  input  logic                  d_rd_mem,
  input  logic                  d_wr_mem,
  input  logic                  d_is_branch,
  input  logic                  d_is_jal,
  output logic [dbits-1:0]      e_alu_out,
  output logic [dbits-1:0]      e_store_data,
  output logic [regno_bits-1:0] e_wregno,
  output logic                  e_wr_reg,
  output logic                  e_rd_mem,
  output logic                  e_wr_mem,
  output logic                  ctrl_in_execute,
  output logic                  redirect,
  output logic [dbits-1:0]      redirect_pc
);

  logic signed [dbits-1:0] a;
  logic signed [dbits-1:0] b;
  logic [$clog2(dbits)-1:0] shamt;
  logic [dbits-1:0]        alu_res;
  logic                    br_cond;
  logic [dbits-1:0]        target;

  // Operands are signed for compares and right shift
  assign a     = d_val1;
  assign b     = d_val2;
  assign shamt = d_val2[$clog2(dbits)-1:0];

  // **************************************************
  // ALU
  // **************************************************
  always_comb begin
    alu_res = '0;
    case (d_inst.alur_fmt.op1)
      op1_alur: begin
        case (d_inst.alur_fmt.op2)
          op2_eq:   alu_res = dbits'(a == b);
          op2_lt:   alu_res = dbits'(a < b);
          op2_le:   alu_res = dbits'(a <= b);
          op2_ne:   alu_res = dbits'(a != b);
          op2_add:  alu_res = a + b;
          op2_and:  alu_res = a & b;
          op2_or:   alu_res = a | b;
          op2_xor:  alu_res = a ^ b;
          op2_sub:  alu_res = a - b;
          op2_nand: alu_res = ~(a & b);
          op2_nor:  alu_res = ~(a | b);
          op2_nxor: alu_res = ~(a ^ b);
          op2_rshf: alu_res = a >>> shamt;
          op2_lshf: alu_res = a << shamt;
          default:  alu_res = '0;
        endcase
      end
      // Address for loads and stores
      op1_lw, op1_sw, op1_addi: alu_res = a + d_imm;
      op1_andi: alu_res = a & d_imm;
      op1_ori:  alu_res = a | d_imm;
      op1_xori: alu_res = a ^ d_imm;
      // Link value
      op1_jal:  alu_res = d_pc + inst_size;
      default:  alu_res = '0;
    endcase
  end

  // Signed branch conditions
  always_comb begin
    case (d_inst.imm_fmt.op1)
      op1_beq: br_cond = (a == b);
      op1_blt: br_cond = (a < b);
      op1_ble: br_cond = (a <= b);
      op1_bne: br_cond = (a != b);
      default: br_cond = 1'b0;
    endcase
  end

  // JAL is register relative, branches are PC relative past the branch
  assign target = d_is_jal ? (d_val1 + (d_imm << 2)) : (d_pc + inst_size + (d_imm << 2));

  assign ctrl_in_execute = d_is_branch | d_is_jal;

  // Execute latch and redirect
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      e_alu_out    <= '0;
      e_store_data <= '0;
      e_wregno     <= '0;
      e_wr_reg     <= 1'b0;
      e_rd_mem     <= 1'b0;
      e_wr_mem     <= 1'b0;
      redirect     <= 1'b0;
      redirect_pc  <= '0;
    end else begin
      e_alu_out    <= alu_res;
      e_store_data <= d_val2;
      e_wregno     <= d_wregno;
      e_wr_reg     <= d_wr_reg;
      e_rd_mem     <= d_rd_mem;
      e_wr_mem     <= d_wr_mem;
      // Not taken needs no redirect, fetch already points past the branch
      redirect     <= (d_is_branch & br_cond) | d_is_jal;
      redirect_pc  <= target;
    end
  end

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [regno_bits-1:0] rs,
  input  logic [regno_bits-1:0] rt,
  input  logic                  wb_en,
  input  logic [regno_bits-1:0] wb_regno,
  input  logic [dbits-1:0]      wb_data,
  output logic [dbits-1:0]      rdata1,
  output logic [dbits-1:0]      rdata2
);

  logic [dbits-1:0] regs [1 << regno_bits];

  // Combinational read ports
  assign rdata1 = regs[rs];
  assign rdata2 = regs[rt];

  // Falling edge write, decode sees it before the next rising edge
  always_ff @(negedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < (1 << regno_bits); i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en) begin
      regs[wb_regno] <= wb_data;
    end
  end

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  inst_t                 inst,
  input  logic [dbits-1:0]      pc,
  input  logic [dbits-1:0]      rdata1,
  input  logic [dbits-1:0]      rdata2,
  output logic [regno_bits-1:0] rs,
  output logic [regno_bits-1:0] rt,
  output inst_t                 d_inst,
  output logic [dbits-1:0]      d_pc,
  output logic [dbits-1:0]      d_val1,
  output logic [dbits-1:0]      d_val2,
  output logic [dbits-1:0]      d_imm,
  output logic [regno_bits-1:0] d_wregno,
  output logic                  d_wr_reg,
  output logic                  d_rd_mem,
  output logic                  d_wr_mem,
  output logic                  d_is_branch,
  output logic                  d_is_jal,
  output logic                  ctrl_in_decode
);

  logic [5:0]            op1;
  logic                  is_alur;
  logic                  is_alui;
  logic                  is_branch;
  logic                  is_jal;
  logic                  is_lw;
  logic                  is_sw;
  logic                  wr_reg;
  logic [regno_bits-1:0] wregno;
  logic [dbits-1:0]      imm_sext;

  // **************************************************
  // Field extraction
  // **************************************************
  assign op1 = inst.alur_fmt.op1;
  assign rs  = inst.alur_fmt.rs;
  assign rt  = inst.alur_fmt.rt;

  // Immediate through the other view of the same word
  assign imm_sext = {{(dbits-imm_bits){inst.imm_fmt.imm[imm_bits-1]}}, inst.imm_fmt.imm};

  // Opcode classes
  assign is_alur   = (op1 == op1_alur);
  assign is_alui   = (op1 == op1_addi) || (op1 == op1_andi) ||
                     (op1 == op1_ori)  || (op1 == op1_xori);
  assign is_branch = (op1 == op1_beq) || (op1 == op1_blt) ||
                     (op1 == op1_ble) || (op1 == op1_bne);
  assign is_jal    = (op1 == op1_jal);
  assign is_lw     = (op1 == op1_lw);
  assign is_sw     = (op1 == op1_sw);

  // Bubble is an ALUR word too, keep it from writing
  assign wr_reg = (is_alur && (inst != nop_inst)) || is_alui || is_lw || is_jal;

  // rd for ALUR, rt for everything else that writes
  assign wregno = is_alur ? inst.alur_fmt.rd : rt;

  // Fetch holds while this stage sees a control instruction
  assign ctrl_in_decode = is_branch | is_jal;

  // Decode latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      d_inst      <= nop_inst;
      d_pc        <= '0;
      d_val1      <= '0;
      d_val2      <= '0;
      d_imm       <= '0;
      d_wregno    <= '0;
      d_wr_reg    <= 1'b0;
      d_rd_mem    <= 1'b0;
      d_wr_mem    <= 1'b0;
      d_is_branch <= 1'b0;
      d_is_jal    <= 1'b0;
    end else begin
      d_inst      <= inst;
      d_pc        <= pc;
      d_val1      <= rdata1;
      d_val2      <= rdata2;
      d_imm       <= imm_sext;
      d_wregno    <= wregno;
      d_wr_reg    <= wr_reg;
      d_rd_mem    <= is_lw;
      d_wr_mem    <= is_sw;
      d_is_branch <= is_branch;
      d_is_jal    <= is_jal;
    end
  end

endmodule

// ==== src/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage import cpu_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic             ctrl_in_decode,
  input  logic             ctrl_in_execute,
  input  logic             redirect,
  input  logic [dbits-1:0] redirect_pc,
  output inst_t            inst,
  output logic [dbits-1:0] pc
);

  // Instruction memory, program image only
  logic [dbits-1:0] imem [mem_words];
  logic [dbits-1:0] pc_q;
  logic [dbits-1:0] fetch_pc;
  logic             hold;

  initial begin
    $readmemh("verif/prog.hex", imem);
  end

  // Control instruction in flight, stop fetching
  assign hold = ctrl_in_decode | ctrl_in_execute;

  // Redirect target goes straight to the memory in the pulse cycle
  assign fetch_pc = redirect ? redirect_pc : pc_q;

  // PC register
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc_q <= start_pc;
    end else if (!hold) begin
      pc_q <= fetch_pc + inst_size;
    end
  end

  // Fetch latch, bubble while held
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      inst <= nop_inst;
      pc   <= '0;
    end else begin
      inst <= hold ? nop_inst : inst_t'(imem[fetch_pc[mem_addr_bits-1:2]]);
      pc   <= fetch_pc;
    end
  end

endmodule

// ==== src/cpu_pkg.sv ====
package cpu_pkg;

  // **************************************************
  // Widths and sizes
  // **************************************************
  localparam int dbits         = 32;
  localparam int regno_bits    = 4;
  localparam int imm_bits      = 16;
  // Byte address bits that index the memories
  localparam int mem_addr_bits = 16;
  // Words per memory, two low bits select the byte
  localparam int mem_words     = 1 << (mem_addr_bits - 2);
  localparam int hex_bits      = 24;
  localparam int key_bits      = 4;

  // **************************************************
  // Addresses and reset values
  // **************************************************
  localparam logic [dbits-1:0]    inst_size = 32'd4;
  localparam logic [dbits-1:0]    start_pc  = 32'h0000_0100;
  localparam logic [dbits-1:0]    addr_hex  = 32'hFFFF_F000;
  localparam logic [dbits-1:0]    addr_key  = 32'hFFFF_F080;
  localparam logic [hex_bits-1:0] hex_reset = 24'hFEDEAD;

  // Primary opcodes
  localparam logic [5:0] op1_alur = 6'b000000;
  localparam logic [5:0] op1_beq  = 6'b001000;
  localparam logic [5:0] op1_blt  = 6'b001001;
  localparam logic [5:0] op1_ble  = 6'b001010;
  localparam logic [5:0] op1_bne  = 6'b001011;
  localparam logic [5:0] op1_jal  = 6'b001100;
  localparam logic [5:0] op1_lw   = 6'b010010;
  localparam logic [5:0] op1_sw   = 6'b011010;
  localparam logic [5:0] op1_addi = 6'b100000;
  localparam logic [5:0] op1_andi = 6'b100100;
  localparam logic [5:0] op1_ori  = 6'b100101;
  localparam logic [5:0] op1_xori = 6'b100110;

  // Secondary opcodes, ALUR only
  localparam logic [7:0] op2_eq   = 8'b00001000;
  localparam logic [7:0] op2_lt   = 8'b00001001;
  localparam logic [7:0] op2_le   = 8'b00001010;
  localparam logic [7:0] op2_ne   = 8'b00001011;
  localparam logic [7:0] op2_add  = 8'b00100000;
  localparam logic [7:0] op2_and  = 8'b00100100;
  localparam logic [7:0] op2_or   = 8'b00100101;
  localparam logic [7:0] op2_xor  = 8'b00100110;
  localparam logic [7:0] op2_sub  = 8'b00101000;
  localparam logic [7:0] op2_nand = 8'b00101100;
  localparam logic [7:0] op2_nor  = 8'b00101101;
  localparam logic [7:0] op2_nxor = 8'b00101110;
  localparam logic [7:0] op2_rshf = 8'b00110000;
  localparam logic [7:0] op2_lshf = 8'b00110001;

  // **************************************************
  // Instruction word, register and immediate views
  // **************************************************
  typedef struct packed {
    logic [5:0]            op1;
    logic [7:0]            op2;
    logic [5:0]            pad;
    logic [regno_bits-1:0] rd;
    logic [regno_bits-1:0] rs;
    logic [regno_bits-1:0] rt;
  } alur_fmt_t;

  typedef struct packed {
    logic [5:0]            op1;
    logic [1:0]            pad;
    logic [imm_bits-1:0]   imm;
    logic [regno_bits-1:0] rs;
    logic [regno_bits-1:0] rt;
  } imm_fmt_t;

  typedef union packed {
    alur_fmt_t alur_fmt;
    imm_fmt_t  imm_fmt;
  } inst_t;

  // All zero, ALUR with an invalid op2 and no write
  localparam inst_t nop_inst = '0;

endpackage
